// File: Makefile
# Verilator flow for the multiply/divide unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module imuldiv_muldiv_iterative
	verilator --lint-only --timing -f sim.f --top-module imuldiv_tb

sim:
	verilator --binary --timing -f sim.f --top-module imuldiv_tb -Mdir obj_dir -o imuldiv_sim
	./obj_dir/imuldiv_sim > sim.log
	cat sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/imuldiv_pkg.sv
// --------------------
// shared types and constants for the iterative
// multiply/divide unit
// --------------------

package imuldiv_pkg;

  // --------------------
  // widths
  // --------------------

  // one operand, quotient or remainder
  typedef logic [31:0] word_t;

  // full product, or {remainder, quotient} for a divide
  typedef logic [63:0] dword_t;

  // iteration counter, wide enough for NUM_ITERS
  typedef logic [5:0] count_t;

  // calculation steps per operation in each unit
  localparam int NUM_ITERS = 32;

  // --------------------
  // encodings
  // --------------------

  // request function code
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_t;

  // states shared by the multiplier and divider FSMs
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_t;

endpackage

// File: div/imuldiv_div_ctrl.sv
// --------------------
// divider control FSM: sequences load, NUM_ITERS steps
// and the response hold
// --------------------
`timescale 1ns/1ps

module imuldiv_div_ctrl
  import imuldiv_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sub_mux_sel
);

  iter_state_t state;
  count_t      count;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_val) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          // last step lands here with count at NUM_ITERS-1
          if (count == count_t'(NUM_ITERS - 1)) begin
            state <= ST_DONE;
          end else begin
            count <= count + count_t'(1);
          end
        end
        ST_DONE: begin
          // hold the result until the consumer takes it
          if (resp_rdy) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // datapath controls
  // --------------------
  always_comb begin
    req_rdy     = (state == ST_IDLE);
    resp_val    = (state == ST_DONE);
    // load both registers on an accepted request
    b_en        = (state == ST_IDLE) && req_val;
    a_en        = b_en || (state == ST_CALC);
    // step mode only while calculating
    a_mux_sel   = (state == ST_CALC);
    sub_mux_sel = (state == ST_CALC);
  end

endmodule

// File: div/imuldiv_div_dpath.sv
// --------------------
// divider datapath: restoring shift-subtract on magnitudes
// with sign fix and divide-by-zero rule at the output
// --------------------
`timescale 1ns/1ps

module imuldiv_div_dpath
  import imuldiv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  word_t  req_a,
  input  word_t  req_b,
  input  logic   req_signed,
  input  logic   a_en,
  input  logic   b_en,
  input  logic   a_mux_sel,
  input  logic   sub_mux_sel,
  output dword_t resp_result
);

  // working register {remainder, quotient} plus guard bit
  logic [64:0] a_reg;
  // divisor aligned to the upper word
  logic [64:0] b_reg;
  logic        a_neg;
  logic        b_neg;
  logic        div_zero;

  // operand magnitudes, only signed requests are flipped
  word_t a_mag;
  word_t b_mag;
  assign a_mag = (req_signed && req_a[31]) ? (~req_a + 32'd1) : req_a;
  assign b_mag = (req_signed && req_b[31]) ? (~req_b + 32'd1) : req_b;

  // --------------------
  // shift-subtract step
  // --------------------
  logic [64:0] init_a;
  logic [64:0] init_b;
  logic [64:0] shifted;
  logic [64:0] diff;
  logic [64:0] step_out;
  assign init_a  = {33'b0, a_mag};
  assign init_b  = {1'b0, b_mag, 32'b0};
  assign shifted = {a_reg[63:0], 1'b0};
  assign diff    = shifted - b_reg;
  // keep the difference when it did not go negative, quotient bit is one
  assign step_out = (sub_mux_sel && !diff[64]) ? {diff[64:1], 1'b1} : shifted;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_sel ? step_out : init_a;
    end
    if (b_en) begin
      b_reg <= init_b;
    end
  end

  // sign bits and zero flag captured with the divisor
  always_ff @(posedge clk) begin
    if (reset) begin
      a_neg    <= 1'b0;
      b_neg    <= 1'b0;
      div_zero <= 1'b0;
    end else if (b_en) begin
      a_neg    <= req_signed && req_a[31];
      b_neg    <= req_signed && req_b[31];
      div_zero <= (req_b == '0);
    end
  end

  // --------------------
  // output sign fix
  // --------------------
  word_t quo;
  word_t rem;
  assign quo = a_reg[31:0];
  assign rem = a_reg[63:32];

  // with a zero divisor the steps leave |a| in the remainder,
  // so the dividend sign fix already gives back req_a there
  assign resp_result[31:0]  = div_zero ? '1 : ((a_neg ^ b_neg) ? (~quo + 32'd1) : quo);
  assign resp_result[63:32] = a_neg ? (~rem + 32'd1) : rem;

endmodule

// File: div/imuldiv_div_iterative.sv
// --------------------
// iterative divider: control FSM plus datapath
// --------------------
`timescale 1ns/1ps

module imuldiv_div_iterative
  import imuldiv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  word_t  req_a,
  input  word_t  req_b,
  input  logic   req_signed,
  input  logic   req_val,
  input  logic   resp_rdy,
  output logic   req_rdy,
  output dword_t resp_result,
  output logic   resp_val
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;

  imuldiv_div_ctrl ctrl0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .resp_rdy    (resp_rdy),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sub_mux_sel (sub_mux_sel)
  );

  imuldiv_div_dpath dpath0 (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (req_signed),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sub_mux_sel (sub_mux_sel),
    .resp_result (resp_result)
  );

endmodule

// File: dv/imuldiv_checker.sv
// --------------------
// checker: models each accepted request and compares
// results, latency and handshake behavior
// --------------------
`timescale 1ns/1ps

module imuldiv_checker
  import imuldiv_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  muldiv_fn_t req_fn,
  input  word_t      req_a,
  input  word_t      req_b,
  input  logic       req_val,
  input  logic       req_rdy,
  input  dword_t     resp_result,
  input  logic       resp_val,
  input  logic       resp_rdy,
  output int         checks,
  output int         errors
);

  // accepting edge counts as zero, resp_val first seen on this edge
  localparam int LATENCY = NUM_ITERS + 1;

  // requests waiting for their response
  muldiv_fn_t fn_q[$];
  word_t      a_q[$];
  word_t      b_q[$];

  int         check_count = 0;
  int         error_count = 0;
  int         cycles;
  logic       in_flight = 1'b0;
  logic       val_seen;
  logic       hold_active = 1'b0;
  logic       after_reset = 1'b0;
  logic       rdy_due = 1'b0;
  dword_t     held_result;
  muldiv_fn_t exp_fn;
  word_t      exp_a;
  word_t      exp_b;
  dword_t     exp_result;

  assign checks = check_count;
  assign errors = error_count;

  function automatic string fn_name(muldiv_fn_t fn);
    case (fn)
      FN_MUL:  return "mul";
      FN_DIV:  return "div";
      default: return "divu";
    endcase
  endfunction

  // reference model, {remainder, quotient} for divides
  function automatic dword_t model(muldiv_fn_t fn, word_t a, word_t b);
    longint la;
    longint lb;
    dword_t r;
    la = longint'($signed(a));
    lb = longint'($signed(b));
    if (fn == FN_MUL) begin
      r = la * lb;
    end else if (b == 32'd0) begin
      // divide by zero gives all ones and the dividend back
      r = {a, 32'hffffffff};
    end else if (fn == FN_DIV && a == 32'h80000000 && b == 32'hffffffff) begin
      r = {32'h00000000, 32'h80000000};
    end else if (fn == FN_DIV) begin
      // truncation toward zero, remainder follows the dividend
      r = {word_t'(la % lb), word_t'(la / lb)};
    end else begin
      r = {a % b, a / b};
    end
    return r;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      fn_q.delete();
      a_q.delete();
      b_q.delete();
      in_flight   = 1'b0;
      hold_active = 1'b0;
      rdy_due     = 1'b0;
      after_reset = 1'b1;
    end else begin
      // --------------------
      // handshake rules
      // --------------------
      if (after_reset) begin
        check_count++;
        if (!req_rdy || resp_val) begin
          $display("unit not idle after reset: req_rdy=%b resp_val=%b", req_rdy, resp_val);
          error_count++;
        end
        after_reset = 1'b0;
      end
      if (rdy_due) begin
        if (!req_rdy) begin
          $display("req_rdy did not return one edge after the response");
          error_count++;
        end
        rdy_due = 1'b0;
      end
      // result must hold while the consumer stalls
      if (hold_active) begin
        check_count++;
        if (!resp_val || resp_result !== held_result) begin
          $display("Error hold: expected %h actual %h (resp_val=%b)",
                   held_result, resp_result, resp_val);
          error_count++;
        end
      end
      if (in_flight) begin
        cycles++;
        if (req_rdy) begin
          $display("req_rdy high while an operation is in flight");
          error_count++;
        end
        if (resp_val && !val_seen) begin
          val_seen = 1'b1;
          check_count++;
          if (cycles != LATENCY) begin
            $display("Error latency: expected %0d actual %0d", LATENCY, cycles);
            error_count++;
          end
        end
      end else if (resp_val) begin
        $display("resp_val high with no operation in flight");
        error_count++;
      end
      // --------------------
      // response compare
      // --------------------
      if (resp_val && resp_rdy && in_flight) begin
        exp_fn     = fn_q.pop_front();
        exp_a      = a_q.pop_front();
        exp_b      = b_q.pop_front();
        exp_result = model(exp_fn, exp_a, exp_b);
        check_count++;
        if (resp_result !== exp_result) begin
          $display("Error %s: a=%h b=%h expected %h actual %h",
                   fn_name(exp_fn), exp_a, exp_b, exp_result, resp_result);
          error_count++;
        end
        in_flight = 1'b0;
        rdy_due   = 1'b1;
      end
      if (req_val && req_rdy) begin
        if (in_flight) begin
          $display("second request accepted while one is in flight");
          error_count++;
        end
        fn_q.push_back(req_fn);
        a_q.push_back(req_a);
        b_q.push_back(req_b);
        in_flight = 1'b1;
        cycles    = 0;
        val_seen  = 1'b0;
      end
      hold_active = resp_val && !resp_rdy;
      held_result = resp_result;
    end
  end

endmodule

// File: dv/imuldiv_tb.sv
// --------------------
// testbench for the multiply/divide unit with random
// requests, gaps and response back-pressure
// --------------------
`timescale 1ns/1ps

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam logic [31:0] SEED = 32'h6e074a8d;
  localparam int NUM_OPS    = 300;
  localparam int WAIT_LIMIT = 200;

  logic       clk;
  logic       reset;
  muldiv_fn_t req_fn;
  word_t      req_a;
  word_t      req_b;
  logic       req_val;
  logic       req_rdy;
  dword_t     resp_result;
  logic       resp_val;
  logic       resp_rdy;

  logic [31:0] rng;
  int          timeouts;
  int          check_count;
  int          error_count;
  muldiv_fn_t  fn;
  word_t       a;
  word_t       b;

  imuldiv_muldiv_iterative dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  imuldiv_checker chk0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .checks      (check_count),
    .errors      (error_count)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // xorshift32 step
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // --------------------
  // stimulus draws
  // --------------------
  task automatic draw_operand(output word_t v);
    rng = next_rand(rng);
    if (rng[1:0] == 2'd0) begin
      // corner values
      case (rng[3:2])
        2'd0:    v = 32'h00000000;
        2'd1:    v = 32'h00000001;
        2'd2:    v = 32'hffffffff;
        default: v = 32'h80000000;
      endcase
    end else if (rng[1:0] == 2'd1) begin
      // small signed values give non-trivial quotients
      v = {{23{rng[12]}}, rng[12:4]};
    end else begin
      rng = next_rand(rng);
      v = rng;
    end
  endtask

  task automatic draw_fn(output muldiv_fn_t f);
    rng = next_rand(rng);
    if (rng[7:0] < 8'd85) begin
      f = FN_MUL;
    end else if (rng[7:0] < 8'd170) begin
      f = FN_DIV;
    end else begin
      f = FN_DIVU;
    end
  endtask

  // --------------------
  // handshakes
  // --------------------
  task automatic send_request(input muldiv_fn_t f, input word_t x, input word_t y);
    int cycles;
    cycles = 0;
    while (!req_rdy && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!req_rdy) begin
      $display("timeout: request not accepted within %0d cycles", WAIT_LIMIT);
      timeouts++;
    end else begin
      req_fn  = f;
      req_a   = x;
      req_b   = y;
      req_val = 1'b1;
      // accepted on the edge in between
      @(negedge clk);
      req_val = 1'b0;
    end
  endtask

  task automatic wait_response();
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      rng = next_rand(rng);
      // ready about 3 cycles in 8
      resp_rdy = (rng[2:0] < 3'd3);
      done     = resp_val && resp_rdy;
      // a stray request while busy must not be accepted
      if (!done && rng[3]) begin
        if (rng[4]) begin
          req_fn = FN_MUL;
        end else begin
          req_fn = FN_DIVU;
        end
        req_a   = rng;
        req_b   = {rng[15:0], rng[31:16]};
        req_val = 1'b1;
      end else begin
        req_val = 1'b0;
      end
      cycles++;
    end
    req_val = 1'b0;
    if (!done) begin
      $display("timeout: no response within %0d cycles", WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic run_op(input muldiv_fn_t f, input word_t x, input word_t y);
    int gap;
    rng = next_rand(rng);
    gap = int'(rng[1:0]);
    repeat (gap) @(negedge clk);
    send_request(f, x, y);
    if (timeouts == 0) begin
      wait_response();
    end
  endtask

  initial begin
    rng      = SEED;
    timeouts = 0;
    reset    = 1'b1;
    req_fn   = FN_MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // directed corners first
    run_op(FN_DIV, 32'h80000000, 32'hffffffff);
    run_op(FN_DIV, 32'hfffffff9, 32'h00000000);
    run_op(FN_DIVU, 32'h12345678, 32'h00000000);
    run_op(FN_DIV, 32'hfffffff9, 32'h00000002);
    run_op(FN_MUL, 32'h80000000, 32'h80000000);
    run_op(FN_MUL, 32'hffffffff, 32'h7fffffff);

    for (int i = 0; i < NUM_OPS && timeouts == 0; i++) begin
      draw_fn(fn);
      draw_operand(a);
      draw_operand(b);
      run_op(fn, a, b);
    end
    repeat (2) @(negedge clk);

    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0 && check_count > 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: sim.f
common/imuldiv_pkg.sv
div/imuldiv_div_dpath.sv
div/imuldiv_div_ctrl.sv
div/imuldiv_div_iterative.sv
verilog/imuldiv_mul_iterative.sv
verilog/imuldiv_muldiv_iterative.sv
dv/imuldiv_checker.sv
dv/imuldiv_tb.sv

// File: verilog/imuldiv_mul_iterative.sv
// --------------------
// iterative signed multiplier: shift-add on magnitudes,
// product negated when the operand signs differ
// --------------------
`timescale 1ns/1ps

module imuldiv_mul_iterative
  import imuldiv_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  word_t  req_a,
  input  word_t  req_b,
  input  logic   req_val,
  input  logic   resp_rdy,
  output logic   req_rdy,
  output dword_t resp_result,
  output logic   resp_val
);

  iter_state_t state;
  count_t      count;

  // multiplicand shifts left, multiplier shifts right
  dword_t mcand;
  word_t  mplier;
  dword_t prod;
  logic   prod_neg;

  word_t a_mag;
  word_t b_mag;
  assign a_mag = req_a[31] ? (~req_a + 32'd1) : req_a;
  assign b_mag = req_b[31] ? (~req_b + 32'd1) : req_b;

  // --------------------
  // FSM, same timing as the divider
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_val) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          if (count == count_t'(NUM_ITERS - 1)) begin
            state <= ST_DONE;
          end else begin
            count <= count + count_t'(1);
          end
        end
        ST_DONE: begin
          if (resp_rdy) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // shift-add datapath
  // --------------------
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req_val) begin
      mcand    <= {32'b0, a_mag};
      mplier   <= b_mag;
      prod     <= '0;
      prod_neg <= req_a[31] ^ req_b[31];
    end else if (state == ST_CALC) begin
      // add partial product for the current multiplier bit
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= {mcand[62:0], 1'b0};
      mplier <= {1'b0, mplier[31:1]};
    end
  end

  assign req_rdy     = (state == ST_IDLE);
  assign resp_val    = (state == ST_DONE);
  assign resp_result = prod_neg ? (~prod + 64'd1) : prod;

endmodule

// File: verilog/imuldiv_muldiv_iterative.sv
// --------------------
// multiply/divide top that steers each request by function
// and returns the owning unit's response
// --------------------
`timescale 1ns/1ps

module imuldiv_muldiv_iterative
  import imuldiv_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  muldiv_fn_t req_fn,
  input  word_t      req_a,
  input  word_t      req_b,
  input  logic       req_val,
  output logic       req_rdy,
  output dword_t     resp_result,
  output logic       resp_val,
  input  logic       resp_rdy
);

  logic   mul_req_val;
  logic   mul_req_rdy;
  logic   mul_resp_val;
  logic   mul_resp_rdy;
  dword_t mul_resp_result;
  logic   div_req_val;
  logic   div_req_rdy;
  logic   div_resp_val;
  logic   div_resp_rdy;
  dword_t div_resp_result;
  logic   div_signed;
  // high when the divider owns the operation in flight
  logic   owner_div;

  // --------------------
  // request steering
  // --------------------
  // a unit only starts on a request the top accepts
  assign mul_req_val = req_val && req_rdy && (req_fn == FN_MUL);
  assign div_req_val = req_val && req_rdy && (req_fn == FN_DIV || req_fn == FN_DIVU);
  assign div_signed  = (req_fn == FN_DIV);
  // one operation in flight, so both units must be idle
  assign req_rdy     = mul_req_rdy && div_req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      owner_div <= (req_fn != FN_MUL);
    end
  end

  // response side follows the owner
  assign resp_val     = owner_div ? div_resp_val : mul_resp_val;
  assign resp_result  = owner_div ? div_resp_result : mul_resp_result;
  assign mul_resp_rdy = resp_rdy && !owner_div;
  assign div_resp_rdy = resp_rdy && owner_div;

  imuldiv_mul_iterative mul0 (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .resp_rdy    (mul_resp_rdy),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val)
  );

  imuldiv_div_iterative div0 (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (div_signed),
    .req_val     (div_req_val),
    .resp_rdy    (div_resp_rdy),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val)
  );

endmodule
